// File: source/regbank_pkg.sv
// sizes, state encodings and shared types of the register bank
// address union, array commands and the AXI4-Lite write payload

package regbank_pkg;

   // bus word and byte lanes
   localparam int DATA_W = 32;
   localparam int STRB_W = 4;
   localparam int BYTE_W = DATA_W / STRB_W;

   // register storage
   localparam int REG_BYTES = 32;
   localparam int REG_WORDS = REG_BYTES / STRB_W;

   // address fields
   localparam int ADDR_W = 5;
   localparam int WORD_IDX_W = 3;
   localparam int LANE_W = 2;

   // slave FSM encoding
   localparam int STATE_W = 2;
   localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
   localparam logic [STATE_W-1:0] ST_WRITE_RESP = 2'd1;
   localparam logic [STATE_W-1:0] ST_READ_RESP = 2'd2;

   // one address word, seen either as a bus byte address
   // or as a word index with a byte lane below it
   typedef union packed {
      logic [ADDR_W-1:0] byte_addr;
      struct packed {
         logic [WORD_IDX_W-1:0] word_idx;
         logic [LANE_W-1:0]     lane;
      } word_lane;
   } regbank_addr_u;

   // write command into the array
   typedef struct packed {
      logic                en;
      regbank_addr_u       addr;
      logic [DATA_W-1:0]   data;
      logic [STRB_W-1:0]   strb;
   } regbank_wr_t;

   // read command into the array
   typedef struct packed {
      logic [WORD_IDX_W-1:0] word_idx;
   } regbank_rd_t;

   // bus side write payload, address and data channels together
   typedef struct packed {
      regbank_addr_u       awaddr;
      logic [DATA_W-1:0]   wdata;
      logic [STRB_W-1:0]   wstrb;
   } axil_wr_chan_t;

endpackage

// File: source/regbank_axil_fsm.sv
`timescale 1ns/100ps
// AXI4-Lite slave FSM of the register bank
// accepts one write pair or one read at a time and drives the array commands

module regbank_axil_fsm import regbank_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // write address and write data channels
   input  logic              awvalid_i,
   output logic              awready_o,
   input  logic              wvalid_i,
   output logic              wready_o,
   input  axil_wr_chan_t     wr_chan_i,

   // write response channel
   output logic              bvalid_o,
   input  logic              bready_i,

   // read address channel
   input  logic              arvalid_i,
   output logic              arready_o,
   input  regbank_addr_u     araddr_i,

   // read data channel
   output logic              rvalid_o,
   input  logic              rready_i,
   output logic [DATA_W-1:0] rdata_o,

   // array side
   output regbank_wr_t       wr_cmd_o,
   output regbank_rd_t       rd_cmd_o,
   input  logic [DATA_W-1:0] rd_word_i
);

   logic [STATE_W-1:0] state_q;
   logic [STATE_W-1:0] state_d;
   logic               in_idle;
   logic               wr_pair;
   logic               wr_accept;
   logic               rd_accept;
   logic [DATA_W-1:0]  rdata_q;

   assign in_idle = (state_q == ST_IDLE);

   // a write needs address and data present in the same cycle
   assign wr_pair = awvalid_i & wvalid_i;
   assign wr_accept = in_idle & wr_pair;

   // reads wait while a complete write pair is pending
   assign rd_accept = in_idle & arvalid_i & ~wr_pair;

   // readies follow the accept decision in the same cycle
   assign awready_o = wr_accept;
   assign wready_o = wr_accept;
   assign arready_o = rd_accept;

   // responses are pure state decodes
   assign bvalid_o = (state_q == ST_WRITE_RESP);
   assign rvalid_o = (state_q == ST_READ_RESP);
   assign rdata_o = rdata_q;

   // bus payload reaches the array only on the accept cycle
   always_comb begin
      wr_cmd_o = '0;
      if (wr_accept) begin
         wr_cmd_o.en = 1'b1;
         wr_cmd_o.addr = wr_chan_i.awaddr;
         wr_cmd_o.data = wr_chan_i.wdata;
         wr_cmd_o.strb = wr_chan_i.wstrb;
      end
   end

   // read word selected by the word part of the byte address
   assign rd_cmd_o.word_idx = araddr_i.word_lane.word_idx;

   // next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (wr_accept) begin
               state_d = ST_WRITE_RESP;
            end else if (rd_accept) begin
               state_d = ST_READ_RESP;
            end
         end
         ST_WRITE_RESP: begin
            // hold bvalid until the master takes it
            if (bready_i) begin
               state_d = ST_IDLE;
            end
         end
         ST_READ_RESP: begin
            // hold rvalid and rdata until the master takes them
            if (rready_i) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // capture the array word on the read accept edge
   // writes from earlier edges are already in the array
   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         rdata_q <= rd_word_i;
      end
   end

endmodule

// File: source/regbank_array.sv
`timescale 1ns/100ps
// byte register array with strobed word writes
// and a combinational word read mux

module regbank_array import regbank_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // write side
   input  regbank_wr_t       wr_cmd_i,

   // read side
   input  regbank_rd_t       rd_cmd_i,
   output logic [DATA_W-1:0] rd_word_o
);

   // byte storage
   logic [BYTE_W-1:0] regs_q [REG_BYTES];

   // per byte write enables
   wire [REG_BYTES-1:0] wen;

   // storage flattened so a word is one contiguous slice
   wire [REG_BYTES*BYTE_W-1:0] regs_flat;

   // rows are words, columns are byte lanes
   genvar row;
   genvar col;

   generate
      for (row = 0; row < REG_WORDS; row = row + 1) begin : g_rows
         for (col = 0; col < STRB_W; col = col + 1) begin : g_cols

            // addressed word and its lane strobe
            assign wen[row*STRB_W+col] = wr_cmd_i.en
                                       & (wr_cmd_i.addr.word_lane.word_idx == WORD_IDX_W'(row))
                                       & wr_cmd_i.strb[col];

            always_ff @(posedge clk_i) begin
               if (!rst_n_i) begin
                  regs_q[row*STRB_W+col] <= '0;
               end else if (wen[row*STRB_W+col]) begin
                  regs_q[row*STRB_W+col] <= wr_cmd_i.data[col*BYTE_W +: BYTE_W];
               end
            end

            // lane 0 sits at the low end of the word
            assign regs_flat[(row*STRB_W+col)*BYTE_W +: BYTE_W] = regs_q[row*STRB_W+col];

         end
      end
   endgenerate

   // word read mux
   assign rd_word_o = regs_flat[rd_cmd_i.word_idx*DATA_W +: DATA_W];

endmodule

// File: source/regbank_top.sv
`timescale 1ns/100ps
// register bank top level
// AXI4-Lite slave FSM in front of the byte register array

module regbank_top import regbank_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // write address and write data channels
   input  logic              awvalid_i,
   output logic              awready_o,
   input  logic              wvalid_i,
   output logic              wready_o,
   input  axil_wr_chan_t     wr_chan_i,

   // write response channel
   output logic              bvalid_o,
   input  logic              bready_i,

   // read address channel
   input  logic              arvalid_i,
   output logic              arready_o,
   input  regbank_addr_u     araddr_i,

   // read data channel
   output logic              rvalid_o,
   input  logic              rready_i,
   output logic [DATA_W-1:0] rdata_o
);

   // commands from the FSM to the array
   regbank_wr_t       wr_cmd;
   regbank_rd_t       rd_cmd;

   // word returned by the array
   logic [DATA_W-1:0] rd_word;

   regbank_axil_fsm regbank_axil_fsm_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .awvalid_i (awvalid_i),
      .awready_o (awready_o),
      .wvalid_i  (wvalid_i),
      .wready_o  (wready_o),
      .wr_chan_i (wr_chan_i),
      .bvalid_o  (bvalid_o),
      .bready_i  (bready_i),
      .arvalid_i (arvalid_i),
      .arready_o (arready_o),
      .araddr_i  (araddr_i),
      .rvalid_o  (rvalid_o),
      .rready_i  (rready_i),
      .rdata_o   (rdata_o),
      .wr_cmd_o  (wr_cmd),
      .rd_cmd_o  (rd_cmd),
      .rd_word_i (rd_word)
   );

   regbank_array regbank_array_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .wr_cmd_i  (wr_cmd),
      .rd_cmd_i  (rd_cmd),
      .rd_word_o (rd_word)
   );

endmodule

// File: dv/regbank_properties.sv
`timescale 1ns/100ps
// protocol and data assertions for the register bank top level
// bound into regbank_top, failures raise assert_failed

module regbank_properties import regbank_pkg::*; (
   input logic              clk_i,
   input logic              rst_n_i,
   input logic              awvalid_i,
   input logic              awready_o,
   input logic              wvalid_i,
   input logic              wready_o,
   input logic              bvalid_o,
   input logic              bready_i,
   input logic              arvalid_i,
   input logic              arready_o,
   input logic              rvalid_o,
   input logic              rready_i,
   input logic [DATA_W-1:0] rdata_o
);

   logic assert_failed = 1'b0;

   // responses idle straight out of reset
   a_reset_idle: assert property (@(posedge clk_i)
      !rst_n_i |=> (!bvalid_o && !rvalid_o))
   else begin
      $error("bvalid or rvalid high after reset");
      assert_failed = 1'b1;
   end

   // both write readies together, only with both valids present
   a_wr_pair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (awready_o || wready_o) |-> (awready_o && wready_o && awvalid_i && wvalid_i))
   else begin
      $error("write ready raised without a complete write pair");
      assert_failed = 1'b1;
   end

   // a complete write pair wins over a pending read
   a_wr_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (awvalid_i && wvalid_i) |-> !arready_o)
   else begin
      $error("read accepted while a write pair was pending");
      assert_failed = 1'b1;
   end

   // bvalid exactly one cycle after the write accept edge
   a_wr_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (awvalid_i && awready_o) |-> !bvalid_o ##1 bvalid_o)
   else begin
      $error("bvalid not one cycle after write accept");
      assert_failed = 1'b1;
   end

   // rvalid exactly one cycle after the read accept edge
   a_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (arvalid_i && arready_o) |-> !rvalid_o ##1 rvalid_o)
   else begin
      $error("rvalid not one cycle after read accept");
      assert_failed = 1'b1;
   end

   // stalled write response holds
   a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (bvalid_o && !bready_i) |=> bvalid_o)
   else begin
      $error("bvalid dropped before bready");
      assert_failed = 1'b1;
   end

   // stalled read response holds with its data
   a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o)))
   else begin
      $error("rvalid or rdata changed before rready");
      assert_failed = 1'b1;
   end

   // nothing new accepted while a response is outstanding
   a_busy_no_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (bvalid_o || rvalid_o) |-> !(awready_o || wready_o || arready_o))
   else begin
      $error("channel ready raised while a response was pending");
      assert_failed = 1'b1;
   end

endmodule

bind regbank_top regbank_properties regbank_properties_inst (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_i),
   .awvalid_i (awvalid_i),
   .awready_o (awready_o),
   .wvalid_i  (wvalid_i),
   .wready_o  (wready_o),
   .bvalid_o  (bvalid_o),
   .bready_i  (bready_i),
   .arvalid_i (arvalid_i),
   .arready_o (arready_o),
   .rvalid_o  (rvalid_o),
   .rready_i  (rready_i),
   .rdata_o   (rdata_o)
);

// File: dv/regbank_tb.sv
`timescale 1ns/100ps
// testbench for the register bank with a byte shadow model
// clock, reset, AXI4-Lite stimulus, readback compare and timeout

module regbank_tb import regbank_pkg::*;;

   localparam int TIMEOUT_CYCLES = 4000;

   logic              clk;
   logic              rst_n;
   logic              awvalid;
   logic              wvalid;
   axil_wr_chan_t     wr_chan;
   logic              bready;
   logic              arvalid;
   regbank_addr_u     araddr;
   logic              rready;
   logic              awready;
   logic              wready;
   logic              bvalid;
   logic              arready;
   logic              rvalid;
   logic [DATA_W-1:0] rdata;

   logic [7:0] model [REG_BYTES];
   integer     seed;
   int         cycle_count;

   regbank_top regbank_top_inst (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .wr_chan_i (wr_chan),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .arvalid_i (arvalid),
      .arready_o (arready),
      .araddr_i  (araddr),
      .rvalid_o  (rvalid),
      .rready_i  (rready),
      .rdata_o   (rdata)
   );

   always #50 clk = ~clk;

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped on failure");
   endtask

   // every strobed lane of the addressed word takes its data byte
   function automatic void update_model(input logic [4:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
      for (int lane = 0; lane < 4; lane++) begin
         if (strb[lane]) begin
            model[addr[4:2]*4+lane] = data[lane*8 +: 8];
         end
      end
   endfunction

   function automatic logic [31:0] expected_word(input logic [2:0] idx);
      return {model[idx*4+3], model[idx*4+2], model[idx*4+1], model[idx*4]};
   endfunction

   task automatic load_payload(input logic [4:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
      wr_chan.awaddr.byte_addr <= addr;
      wr_chan.wdata <= data;
      wr_chan.wstrb <= strb;
   endtask

   task automatic start_write(input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      load_payload(addr, data, strb);
      awvalid <= 1'b1;
      wvalid <= 1'b1;
   endtask

   // accept edge and then the response with bready held off for stall cycles
   task automatic finish_write(input logic [4:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input int stall);
      do @(posedge clk); while (!(awvalid && awready));
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      update_model(addr, data, strb);
      bready <= (stall == 0);
      repeat (stall) @(posedge clk);
      bready <= 1'b1;
      do @(posedge clk); while (!(bvalid && bready));
      bready <= 1'b0;
   endtask

   task automatic start_read(input logic [4:0] addr);
      araddr.byte_addr <= addr;
      arvalid <= 1'b1;
   endtask

   task automatic finish_read(input logic [4:0] addr, input int stall);
      logic [31:0] exp;
      do @(posedge clk); while (!(arvalid && arready));
      arvalid <= 1'b0;
      // address moves on so the array word changes under a stalled response
      araddr.byte_addr <= addr + 5'd4;
      exp = expected_word(addr[4:2]);
      rready <= (stall == 0);
      repeat (stall) @(posedge clk);
      rready <= 1'b1;
      do @(posedge clk); while (!(rvalid && rready));
      rready <= 1'b0;
      if (rdata !== exp) begin
         $display("ERROR: time %0t rdata expected %h actual %h", $time, exp, rdata);
         abort_run();
      end
   endtask

   task automatic write_word(input logic [4:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall);
      start_write(addr, data, strb);
      finish_write(addr, data, strb, stall);
   endtask

   task automatic read_word(input logic [4:0] addr, input int stall);
      start_read(addr);
      finish_read(addr, stall);
   endtask

   // address and data channels arrive gap cycles apart
   task automatic write_split(input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic aw_first, input int gap);
      load_payload(addr, data, strb);
      if (aw_first) begin
         awvalid <= 1'b1;
      end else begin
         wvalid <= 1'b1;
      end
      repeat (gap) @(posedge clk);
      awvalid <= 1'b1;
      wvalid <= 1'b1;
      finish_write(addr, data, strb, 0);
   endtask

   // write pair and read raised together so the read waits behind the write
   task automatic write_with_read(input logic [4:0] waddr, input logic [31:0] data,
                                  input logic [3:0] strb, input logic [4:0] raddr,
                                  input int bstall, input int rstall);
      start_write(waddr, data, strb);
      start_read(raddr);
      finish_write(waddr, data, strb, bstall);
      finish_read(raddr, rstall);
   endtask

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // timeout and assertion flag watch
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end else if (regbank_top_inst.regbank_properties_inst.assert_failed) begin
         $display("a protocol assertion failed");
         abort_run();
      end
   end

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      awvalid = 1'b0;
      wvalid = 1'b0;
      wr_chan = '0;
      bready = 1'b0;
      arvalid = 1'b0;
      araddr = '0;
      rready = 1'b0;
      cycle_count = 0;
      seed = 32'hf2e4fa5e;
      for (int b = 0; b < REG_BYTES; b++) begin
         model[b] = 8'h00;
      end

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // all words zero after reset
      for (int w = 0; w < REG_WORDS; w++) begin
         read_word(5'(w*4), 0);
      end

      // full strobe writes then readback
      for (int w = 0; w < REG_WORDS; w++) begin
         write_word(5'(w*4), $random(seed), 4'hf, 0);
      end
      for (int w = 0; w < REG_WORDS; w++) begin
         read_word(5'(w*4), 0);
      end

      // random partial strobes with varying lane bits in the address
      for (int i = 0; i < 24; i++) begin
         logic [4:0] addr;
         addr = 5'($random(seed));
         write_word(addr, $random(seed), 4'($random(seed)), 0);
         read_word(addr, 0);
      end

      // channels arriving apart and then write against read priority
      for (int i = 0; i < 4; i++) begin
         logic [4:0] addr;
         addr = 5'($random(seed));
         write_split(addr, $random(seed), 4'($random(seed)), i[0], 1 + rand_below(3));
         read_word(addr, 0);
         write_with_read(addr, $random(seed), 4'($random(seed)), addr, 0, 0);
      end

      // response back-pressure with random stalls
      for (int i = 0; i < 12; i++) begin
         logic [4:0] addr;
         addr = 5'($random(seed));
         write_word(addr, $random(seed), 4'($random(seed)), rand_below(8));
         read_word(addr, rand_below(8));
         write_with_read(addr, $random(seed), 4'($random(seed)), 5'($random(seed)),
                         rand_below(8), rand_below(8));
      end

      repeat (2) @(posedge clk);
      if (regbank_top_inst.regbank_properties_inst.assert_failed) begin
         $display("a protocol assertion failed");
         abort_run();
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

// File: regbank.f
source/regbank_pkg.sv
source/regbank_axil_fsm.sv
source/regbank_array.sv
source/regbank_top.sv
dv/regbank_properties.sv
dv/regbank_tb.sv
